// ==== bench/prefix_adder_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefix_adder_props (
    input logic                               clk,
    input logic                               rst,
    input logic [adder_pkg::data_width-1:0]   a,
    input logic [adder_pkg::data_width-1:0]   b,
    input logic [adder_pkg::ctr_width-1:0]    ctr_in,
    input logic                               flag_in,
    input logic [adder_pkg::remain_width-1:0] remain_in,
    input logic [adder_pkg::result_width-1:0] sum_hi,
    input logic [adder_pkg::ctr_width-1:0]    ctr_out,
    input logic                               flag_out,
    input logic [adder_pkg::remain_width-1:0] remain_out
);

    import adder_pkg::*;

    // inputs taken at edge N are visible here when sampled at edge N+3
    localparam int check_lag = pipe_depth;

    // number of property failures so far
    int fail_count = 0;

    // upper window of the wrapped 32-bit sum
    function automatic logic [result_width-1:0] window_of(
        input logic [data_width-1:0] x,
        input logic [data_width-1:0] y
    );
        logic [data_width-1:0] s;
        s = x + y;
        return s[data_width-1:result_lsb];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reset and timing
    ////////////////////////////////////////////////////////////////////////////

    reset_clears: assert property (@(posedge clk)
        !rst |=> (sum_hi == '0 && ctr_out == '0 && !flag_out && remain_out == '0))
        else begin
            fail_count++;
            $error("outputs were not cleared by reset");
        end

    outputs_known: assert property (@(posedge clk)
        rst |-> !$isunknown({sum_hi, ctr_out, flag_out, remain_out}))
        else begin
            fail_count++;
            $error("an output is unknown outside reset");
        end

    // needs reset high across the whole trip through the pipeline
    sum_follows_inputs: assert property (@(posedge clk)
        rst [*check_lag] |=>
            sum_hi == window_of($past(a, check_lag), $past(b, check_lag)))
        else begin
            fail_count++;
            $error("sum_hi does not match the operands sampled three cycles before");
        end

    sideband_follows_inputs: assert property (@(posedge clk)
        rst [*check_lag] |=>
            {ctr_out, flag_out, remain_out} ==
                $past({ctr_in, flag_in, remain_in}, check_lag))
        else begin
            fail_count++;
            $error("sideband outputs are not aligned with their operands");
        end

endmodule

bind prefix_adder prefix_adder_props u_props (
    .clk        (clk),
    .rst        (rst),
    .a          (a),
    .b          (b),
    .ctr_in     (ctr_in),
    .flag_in    (flag_in),
    .remain_in  (remain_in),
    .sum_hi     (sum_hi),
    .ctr_out    (ctr_out),
    .flag_out   (flag_out),
    .remain_out (remain_out)
);

`default_nettype wire

// ==== bench/tb_prefix_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_prefix_adder;

    import adder_pkg::*;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 3;
    localparam int num_zero     = 3;
    localparam int num_corner   = 8;
    localparam int num_random   = 240;
    localparam int num_vectors  = num_zero + num_corner + num_random;
    localparam int watchdog_ns  = (num_vectors + 20) * clk_period;

    // test ids, carried through the model next to each expected value
    localparam logic [7:0] t_reset  = 8'd0;
    localparam logic [7:0] t_zero   = 8'd1;
    localparam logic [7:0] t_chain  = 8'd2;
    localparam logic [7:0] t_alt    = 8'd3;
    localparam logic [7:0] t_corner = 8'd4;
    localparam logic [7:0] t_burst  = 8'd5;

    typedef struct packed {
        logic [result_width-1:0] sum;
        logic [ctr_width-1:0]    ctr;
        logic                    flag;
        logic [remain_width-1:0] remain;
        logic [7:0]              test_id;
    } expect_t;

    logic                    clk;
    logic                    rst;
    logic [data_width-1:0]   a;
    logic [data_width-1:0]   b;
    logic [ctr_width-1:0]    ctr_in;
    logic                    flag_in;
    logic [remain_width-1:0] remain_in;
    logic [result_width-1:0] sum_hi;
    logic [ctr_width-1:0]    ctr_out;
    logic                    flag_out;
    logic [remain_width-1:0] remain_out;

    // marks an applied operand pair as opposed to idle inputs
    logic       vec_real;
    logic [7:0] vec_test;

    expect_t     exp_q[$];
    expect_t     exp_now      = '0;
    logic        model_ready  = 1'b0;
    logic [31:0] rng_state    = 32'd47;

    prefix_adder uut (
        .clk        (clk),
        .rst        (rst),
        .a          (a),
        .b          (b),
        .ctr_in     (ctr_in),
        .flag_in    (flag_in),
        .remain_in  (remain_in),
        .sum_hi     (sum_hi),
        .ctr_out    (ctr_out),
        .flag_out   (flag_out),
        .remain_out (remain_out)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string test_label(input logic [7:0] id);
        string s;
        case (id)
            t_reset:  s = "reset";
            t_zero:   s = "zero_after_reset";
            t_chain:  s = "full_carry_chain";
            t_alt:    s = "alternating_bits";
            t_corner: s = "corner_cases";
            default:  s = "back_to_back_random";
        endcase
        return s;
    endfunction

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "run stopped after a failure");
    endtask

    task automatic report_mismatch(
        input string       what,
        input logic [7:0]  test_id,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h",
                 test_label(test_id), what, expected, actual);
        abort_run();
    endtask

    task automatic apply_vector(
        input logic [7:0]              test_id,
        input logic [data_width-1:0]   op_a,
        input logic [data_width-1:0]   op_b,
        input logic [ctr_width-1:0]    ctr,
        input logic                    flag,
        input logic [remain_width-1:0] remain
    );
        @(posedge clk);
        a         <= op_a;
        b         <= op_b;
        ctr_in    <= ctr;
        flag_in   <= flag;
        remain_in <= remain;
        vec_real  <= 1'b1;
        vec_test  <= test_id;
    endtask

    task automatic apply_random(input logic [7:0] test_id);
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] side;
        rng_state = xorshift32(rng_state);
        op_a      = rng_state;
        rng_state = xorshift32(rng_state);
        op_b      = rng_state;
        rng_state = xorshift32(rng_state);
        side      = rng_state;
        apply_vector(test_id, op_a, op_b, side[ctr_width-1:0], side[ctr_width],
                     side[ctr_width+remain_width:ctr_width+1]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model, one entry per pipeline stage
    ////////////////////////////////////////////////////////////////////////////

    // exp_now stands for the last stage, the queue for the stages before it
    always @(posedge clk) begin
        expect_t               entry;
        logic [data_width-1:0] full_sum;
        if (!rst) begin
            entry         = '0;
            entry.test_id = t_reset;
            exp_q.delete();
            for (int i = 0; i < pipe_depth - 1; i++) begin
                exp_q.push_back(entry);
            end
            exp_now     = entry;
            model_ready = 1'b1;
        end else begin
            full_sum      = a + b;
            entry.sum     = full_sum[data_width-1:result_lsb];
            entry.ctr     = ctr_in;
            entry.flag    = flag_in;
            entry.remain  = remain_in;
            entry.test_id = vec_real ? vec_test : t_zero;
            exp_now = exp_q.pop_front();
            exp_q.push_back(entry);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    sum_check: assert property (@(posedge clk) model_ready |-> sum_hi == exp_now.sum)
        else report_mismatch("sum_hi", $sampled(exp_now.test_id),
                             $sampled(exp_now.sum), $sampled(sum_hi));

    ctr_check: assert property (@(posedge clk) model_ready |-> ctr_out == exp_now.ctr)
        else report_mismatch("ctr_out", $sampled(exp_now.test_id),
                             $sampled(exp_now.ctr), $sampled(ctr_out));

    flag_check: assert property (@(posedge clk) model_ready |-> flag_out == exp_now.flag)
        else report_mismatch("flag_out", $sampled(exp_now.test_id),
                             $sampled(exp_now.flag), $sampled(flag_out));

    remain_check: assert property (@(posedge clk)
        model_ready |-> remain_out == exp_now.remain)
        else report_mismatch("remain_out", $sampled(exp_now.test_id),
                             $sampled(exp_now.remain), $sampled(remain_out));

    // failures of the bound property checks
    initial begin
        wait (uut.u_props.fail_count != 0);
        $display("a bound property check on the DUT failed");
        abort_run();
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        a         = '0;
        b         = '0;
        ctr_in    = '0;
        flag_in   = 1'b0;
        remain_in = '0;
        vec_real  = 1'b0;
        vec_test  = t_reset;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b1;
        // zero operands while the cleared pipeline drains
        repeat (num_zero) apply_vector(t_zero, '0, '0, '0, 1'b0, '0);
        // carry ripples through every prefix level
        apply_vector(t_chain, 32'hffff_ffff, 32'h0000_0001, 3'd5, 1'b1, 10'h3ff);
        apply_vector(t_chain, 32'h0000_0001, 32'hffff_ffff, 3'd2, 1'b0, 10'h155);
        apply_vector(t_alt, 32'haaaa_aaaa, 32'h5555_5555, 3'd7, 1'b1, 10'h2aa);
        apply_vector(t_alt, 32'h5555_5555, 32'h5555_5555, 3'd1, 1'b0, 10'h001);
        apply_vector(t_alt, 32'haaaa_aaaa, 32'haaaa_aaaa, 3'd6, 1'b1, 10'h200);
        // carry into the lowest window bit
        apply_vector(t_corner, 32'h0000_007f, 32'h0000_0001, 3'd3, 1'b0, 10'h0f0);
        // carry out of bit 31 is dropped
        apply_vector(t_corner, 32'h8000_0000, 32'h8000_0000, 3'd4, 1'b1, 10'h00f);
        apply_vector(t_corner, 32'hffff_ffff, 32'hffff_ffff, 3'd0, 1'b0, 10'h3c3);
        // new pair every cycle, no gaps
        repeat (num_random) apply_random(t_burst);
        @(posedge clk);
        a        <= '0;
        b        <= '0;
        vec_real <= 1'b0;
        repeat (pipe_depth + 2) @(posedge clk);
        @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        abort_run();
    end

endmodule

`default_nettype wire

// ==== src/adder_pkg.sv ====
`default_nettype none

package adder_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////////////////////

    // operand width, no carry-in and no carry-out
    localparam int data_width = 32;

    // delivered window is sum[data_width-1:result_lsb]
    localparam int result_lsb   = 7;
    localparam int result_width = data_width - result_lsb;

    ////////////////////////////////////////////////////////////////////////////
    // stage layout
    ////////////////////////////////////////////////////////////////////////////

    localparam int prefix_levels    = 6;
    localparam int levels_per_stage = 2;

    // one register after every levels_per_stage prefix levels
    localparam int pipe_depth = prefix_levels / levels_per_stage;

    ////////////////////////////////////////////////////////////////////////////
    // sideband fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int ctr_width    = 3;
    localparam int remain_width = 10;

    // prefix word passed between the adder stages
    typedef struct packed {
        logic [data_width-1:0] g;
        logic [data_width-1:0] p;
        logic [data_width-1:0] half_sum;
    } pg_word_t;

    // caller fields that ride along with each operand pair
    typedef struct packed {
        logic [ctr_width-1:0]    ctr;
        logic                    flag;
        logic [remain_width-1:0] remain;
    } sideband_t;

endpackage

`default_nettype wire

// ==== src/pg_front.sv ====
`timescale 1ns/1ps
`default_nettype none

module pg_front (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [adder_pkg::data_width-1:0] a,
    input  logic [adder_pkg::data_width-1:0] b,
    output adder_pkg::pg_word_t              pg_out
);

    import adder_pkg::*;

    // bit-level generate and propagate
    logic [data_width-1:0] g_bit;
    logic [data_width-1:0] p_bit;

    // group terms after level 0 (pairs)
    logic [data_width-1:0] g_l0;
    logic [data_width-1:0] p_l0;

    // group terms after level 1 (groups of four)
    logic [data_width-1:0] g_l1;
    logic [data_width-1:0] p_l1;

    assign g_bit = a & b;
    assign p_bit = a ^ b;

    ////////////////////////////////////////////////////////////////////////////
    // level 0
    ////////////////////////////////////////////////////////////////////////////

    // odd bits take in their even neighbour
    for (genvar i = 0; i < data_width; i++) begin : g_lvl0
        if (i % 2 == 1) begin : g_merge
            assign g_l0[i] = g_bit[i] | (p_bit[i] & g_bit[i-1]);
            assign p_l0[i] = p_bit[i] & p_bit[i-1];
        end else begin : g_keep
            assign g_l0[i] = g_bit[i];
            assign p_l0[i] = p_bit[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // level 1
    ////////////////////////////////////////////////////////////////////////////

    // upper pair of each group of four takes in bit 1 of that group
    for (genvar i = 0; i < data_width; i++) begin : g_lvl1
        if (i % 4 >= 2) begin : g_merge
            localparam int src = (i / 4) * 4 + 1;

            assign g_l1[i] = g_l0[i] | (p_l0[i] & g_l0[src]);
            assign p_l1[i] = p_l0[i] & p_l0[src];
        end else begin : g_keep
            assign g_l1[i] = g_l0[i];
            assign p_l1[i] = p_l0[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // first pipeline register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            pg_out <= '0;
        end else begin
            pg_out.g        <= g_l1;
            pg_out.p        <= p_l1;
            // plain bit propagate is kept for the final xor
            pg_out.half_sum <= p_bit;
        end
    end

endmodule

`default_nettype wire

// ==== src/prefix_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefix_adder (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [adder_pkg::data_width-1:0]   a,
    input  logic [adder_pkg::data_width-1:0]   b,
    input  logic [adder_pkg::ctr_width-1:0]    ctr_in,
    input  logic                               flag_in,
    input  logic [adder_pkg::remain_width-1:0] remain_in,
    output logic [adder_pkg::result_width-1:0] sum_hi,
    output logic [adder_pkg::ctr_width-1:0]    ctr_out,
    output logic                               flag_out,
    output logic [adder_pkg::remain_width-1:0] remain_out
);

    import adder_pkg::*;

    // registered prefix words between the stages
    pg_word_t pg_s1;
    pg_word_t pg_s2;
    pg_word_t pg_s3;

    sideband_t side_in;
    sideband_t side_out;

    ////////////////////////////////////////////////////////////////////////////
    // adder datapath
    ////////////////////////////////////////////////////////////////////////////

    // bit terms and levels 0 and 1
    pg_front u_pg_front (
        .clk    (clk),
        .rst    (rst),
        .a      (a),
        .b      (b),
        .pg_out (pg_s1)
    );

    // levels 2 and 3
    prefix_stage #(
        .first_level (2)
    ) u_stage_l2 (
        .clk    (clk),
        .rst    (rst),
        .pg_in  (pg_s1),
        .pg_out (pg_s2)
    );

    // levels 4 and 5
    prefix_stage #(
        .first_level (4)
    ) u_stage_l4 (
        .clk    (clk),
        .rst    (rst),
        .pg_in  (pg_s2),
        .pg_out (pg_s3)
    );

    sum_window u_sum_window (
        .pg_in  (pg_s3),
        .sum_hi (sum_hi)
    );

    ////////////////////////////////////////////////////////////////////////////
    // sideband alignment
    ////////////////////////////////////////////////////////////////////////////

    assign side_in = '{ctr: ctr_in, flag: flag_in, remain: remain_in};

    sideband_pipe u_sideband_pipe (
        .clk      (clk),
        .rst      (rst),
        .side_in  (side_in),
        .side_out (side_out)
    );

    assign ctr_out    = side_out.ctr;
    assign flag_out   = side_out.flag;
    assign remain_out = side_out.remain;

endmodule

`default_nettype wire

// ==== src/prefix_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefix_stage #(
    parameter int first_level = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  adder_pkg::pg_word_t pg_in,
    output adder_pkg::pg_word_t pg_out
);

    import adder_pkg::*;

    // entry 0 is the stage input, entry n is the result after n levels
    logic [data_width-1:0] g_lvl [levels_per_stage+1];
    logic [data_width-1:0] p_lvl [levels_per_stage+1];

    assign g_lvl[0] = pg_in.g;
    assign p_lvl[0] = pg_in.p;

    ////////////////////////////////////////////////////////////////////////////
    // sklansky levels first_level .. first_level+levels_per_stage-1
    ////////////////////////////////////////////////////////////////////////////

    for (genvar l = 0; l < levels_per_stage; l++) begin : g_level
        // absolute level index, block size is 2**(lvl+1)
        localparam int lvl = first_level + l;

        for (genvar i = 0; i < data_width; i++) begin : g_bit
            // bit i sits in the upper half of its block when bit lvl of i is set
            if (((i >> lvl) & 1) == 1) begin : g_merge
                // top bit of the lower half of the same block
                localparam int src = ((i >> (lvl + 1)) << (lvl + 1)) + (1 << lvl) - 1;

                assign g_lvl[l+1][i] = g_lvl[l][i] | (p_lvl[l][i] & g_lvl[l][src]);
                assign p_lvl[l+1][i] = p_lvl[l][i] & p_lvl[l][src];
            end else begin : g_keep
                // also covers a top level with a block wider than the word
                assign g_lvl[l+1][i] = g_lvl[l][i];
                assign p_lvl[l+1][i] = p_lvl[l][i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            pg_out <= '0;
        end else begin
            pg_out.g        <= g_lvl[levels_per_stage];
            pg_out.p        <= p_lvl[levels_per_stage];
            // half-sum rides along untouched
            pg_out.half_sum <= pg_in.half_sum;
        end
    end

endmodule

`default_nettype wire

// ==== src/sideband_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module sideband_pipe (
    input  logic                 clk,
    input  logic                 rst,
    input  adder_pkg::sideband_t side_in,
    output adder_pkg::sideband_t side_out
);

    import adder_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // delay line, one entry per adder register stage
    ////////////////////////////////////////////////////////////////////////////

    // entry 0 is loaded alongside pg_front, the last entry with the final stage
    sideband_t stage_q [pipe_depth];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < pipe_depth; s++) begin
                stage_q[s] <= '0;
            end
        end else begin
            stage_q[0] <= side_in;
            for (int s = 1; s < pipe_depth; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    // leaves in the same cycle as the matching sum window
    assign side_out = stage_q[pipe_depth-1];

endmodule

`default_nettype wire

// ==== src/sum_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module sum_window (
    input  adder_pkg::pg_word_t                pg_in,
    output logic [adder_pkg::result_width-1:0] sum_hi
);

    import adder_pkg::*;

    // only the window bits of the sum are built
    for (genvar i = result_lsb; i < data_width; i++) begin : g_sum
        if (i == 0) begin : g_lsb
            // no carry-in, so bit 0 is the half-sum itself
            assign sum_hi[i-result_lsb] = pg_in.half_sum[0];
        end else begin : g_xor
            // carry into bit i is the group generate of bits i-1 .. 0
            assign sum_hi[i-result_lsb] = pg_in.half_sum[i] ^ pg_in.g[i-1];
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/adder_pkg.sv
src/pg_front.sv
src/prefix_stage.sv
src/sum_window.sv
src/sideband_pipe.sv
src/prefix_adder.sv
bench/prefix_adder_props.sv
bench/tb_prefix_adder.sv
